// ==== ppu_bg.f ====
+incdir+common
common/ppu_reg_pkg.sv
common/ppu_pix_pkg.sv
logic/dot_timer.sv
fetcher/bg_fetcher.sv
logic/bg_fifo.sv
logic/pixel_shifter.sv
logic/ppu_bg_top.sv
test/vram_model.sv
test/tb_ppu_bg.sv

// ==== test/tb_ppu_bg.sv ====
`default_nettype none

`include "ppu_params.svh"

module tb_ppu_bg;

  // each test may spend up to three lines, plus slack for reset
  localparam int timeout_cycles = 6 * 3 * `DOTS_PER_LINE + 1000;

  logic                    clk;
  logic                    reset;
  ppu_reg_pkg::ppu_regs_t  regs;
  logic                    vram_read_req;
  logic [15:0]             vram_addr;
  logic [7:0]              vram_rdata;
  logic                    lcd_valid;
  ppu_pix_pkg::lcd_pixel_t lcd_px;
  logic [7:0]              ly;
  logic                    mode3;

  int          errors;
  int          checks;
  int          cycle_count;
  // dots since reset was released, kept apart from the DUT counters
  int          dot_count;
  logic [31:0] rand_state;

  ppu_bg_top uut (
    .clk           (clk),
    .reset         (reset),
    .regs          (regs),
    .vram_read_req (vram_read_req),
    .vram_addr     (vram_addr),
    .vram_rdata    (vram_rdata),
    .lcd_valid     (lcd_valid),
    .lcd_px        (lcd_px),
    .ly            (ly),
    .mode3         (mode3)
  );

  vram_model vram (
    .addr  (vram_addr),
    .rdata (vram_rdata)
  );

  // one dot per clock
  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      dot_count <= 0;
    end else begin
      dot_count <= dot_count + 1;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // expected shade of screen column x on a line, straight from memory contents
  function automatic logic [1:0] ref_shade(input ppu_reg_pkg::ppu_regs_t r,
                                           input logic [7:0] line, input int x);
    logic [7:0]  bg_y;
    logic [15:0] map_a;
    logic [15:0] row_a;
    logic [7:0]  idx;
    logic [7:0]  lo;
    logic [7:0]  hi;
    int          col;
    int          bit_n;
    int          c;
    bg_y  = r.scy + line;
    col   = ((r.scx + x) / 8) % 32;
    map_a = (r.lcdc[3] ? `MAP_BASE_HI : `MAP_BASE_LO) + 16'(32 * bg_y[7:3]) + 16'(col);
    idx   = vram.read_byte(map_a);
    if (r.lcdc[4]) begin
      row_a = `TILE_BASE_U + 16'(16 * idx);
    end else begin
      // tile index is two's complement around 0x9000
      row_a = 16'(int'(`TILE_BASE_S) + 16 * $signed(idx));
    end
    row_a = row_a + 16'(2 * bg_y[2:0]);
    lo    = vram.read_byte(row_a);
    hi    = vram.read_byte(row_a + 16'd1);
    bit_n = 7 - ((r.scx + x) % 8);
    c     = {hi[bit_n], lo[bit_n]};
    return r.bgp[2 * c +: 2];
  endfunction

  task automatic check_pixel(input string name, input ppu_pix_pkg::lcd_pixel_t exp,
                             input ppu_pix_pkg::lcd_pixel_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected shade %0d x %0d, actual shade %0d x %0d",
               name, exp.shade, exp.x, act.shade, act.x);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("error %s: expected %0d pixels, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_line(input string name, input logic [7:0] exp,
                            input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected line %0d, actual line %0d", name, exp, act);
    end
  endtask

  task automatic set_regs(input ppu_reg_pkg::ppu_regs_t cfg);
    @(posedge clk);
    regs <= cfg;
  endtask

  // called on the first dot of mode 3, checks timing and every pixel of that line
  task automatic collect_line(input string name, input ppu_reg_pkg::ppu_regs_t cfg);
    ppu_pix_pkg::lcd_pixel_t exp;
    logic [7:0]              line;
    int                      count;
    count = 0;
    // line and dot follow from the time since reset
    line  = 8'((dot_count / `DOTS_PER_LINE) % `LINES_PER_FRAME);
    check_line(name, line, ly);
    checks++;
    if (dot_count % `DOTS_PER_LINE != `MODE3_START_DOT + 1) begin
      errors++;
      $display("%s: mode 3 opened at dot %0d of the line instead of dot %0d",
               name, dot_count % `DOTS_PER_LINE, `MODE3_START_DOT + 1);
    end
    // last pixel shows up with line_done, mode3 drops one dot later
    while (mode3 || lcd_valid) begin
      if (lcd_valid) begin
        exp.x     = 8'(count);
        exp.shade = ref_shade(cfg, line, count);
        check_pixel(name, exp, lcd_px);
        count++;
      end
      @(negedge clk);
    end
    check_count(name, `SCREEN_W, count);
  endtask

  // waits for the next mode 3, then checks that line
  task automatic run_line(input string name, input ppu_reg_pkg::ppu_regs_t cfg);
    @(negedge clk);
    while (!mode3) begin
      @(negedge clk);
    end
    collect_line(name, cfg);
  endtask

  // whole video memory from the lcg
  task automatic fill_vram();
    logic [31:0] r;
    for (int a = 0; a < 8192; a++) begin
      r = next_rand();
      vram.write_byte(16'h8000 + 16'(a), r[23:16]);
    end
  endtask

  // even map columns get indices 128..255 so the signed range is hit on every line
  task automatic force_high_indices();
    logic [15:0] a;
    logic [7:0]  d;
    for (int i = 0; i < 1024; i++) begin
      a = `MAP_BASE_LO + 16'(i);
      d = vram.read_byte(a);
      vram.write_byte(a, a[0] ? (d & 8'h7F) : (d | 8'h80));
    end
  endtask

  task automatic reset_idle_line();
    ppu_reg_pkg::ppu_regs_t cfg;
    cfg = '{lcdc: 8'h10, scy: 8'h00, scx: 8'h00, bgp: 8'hE4};
    set_regs(cfg);
    @(negedge clk);
    // nothing may move before the first mode 3
    while (!mode3) begin
      checks++;
      if (lcd_valid || vram_read_req) begin
        errors++;
        $display("reset_idle: pixel or memory read seen before the first line started");
      end
      @(negedge clk);
    end
    collect_line("reset_idle", cfg);
  endtask

  task automatic unsigned_tiles();
    ppu_reg_pkg::ppu_regs_t cfg;
    cfg = '{lcdc: 8'h10, scy: 8'h00, scx: 8'h00, bgp: 8'hE4};
    set_regs(cfg);
    run_line("unsigned_tiles", cfg);
  endtask

  task automatic signed_tiles();
    ppu_reg_pkg::ppu_regs_t cfg;
    cfg = '{lcdc: 8'h00, scy: 8'h00, scx: 8'h00, bgp: 8'hE4};
    force_high_indices();
    set_regs(cfg);
    run_line("signed_tiles", cfg);
  endtask

  task automatic scrolled_x();
    ppu_reg_pkg::ppu_regs_t cfg;
    logic [31:0]            r;
    r   = next_rand();
    cfg = '{lcdc: 8'h10, scy: 8'h00, scx: r[23:16] | 8'h80, bgp: 8'hE4};
    // nonzero fine part, and coarse part high enough to wrap past column 31
    if (cfg.scx[2:0] == 3'd0) begin
      cfg.scx[0] = 1'b1;
    end
    set_regs(cfg);
    run_line("scrolled_x", cfg);
  endtask

  task automatic scrolled_y_high_map();
    ppu_reg_pkg::ppu_regs_t cfg;
    logic [31:0]            r;
    r   = next_rand();
    cfg = '{lcdc: 8'h18, scy: r[23:16], scx: 8'h00, bgp: 8'hE4};
    set_regs(cfg);
    // two consecutive lines
    run_line("scrolled_y_a", cfg);
    run_line("scrolled_y_b", cfg);
  endtask

  task automatic random_palette();
    ppu_reg_pkg::ppu_regs_t cfg;
    logic [31:0]            r;
    r   = next_rand();
    cfg = '{lcdc: 8'h10, scy: 8'h00, scx: 8'h00, bgp: r[23:16]};
    set_regs(cfg);
    run_line("random_palette", cfg);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    regs       = '0;
    errors     = 0;
    checks     = 0;
    rand_state = 32'h9a1e;
    fill_vram();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    reset_idle_line();
    unsigned_tiles();
    signed_tiles();
    scrolled_x();
    scrolled_y_high_map();
    random_palette();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/vram_model.sv ====
`default_nettype none

`include "ppu_params.svh"

module vram_model (
  input  logic [15:0] addr,
  output logic [7:0]  rdata
);

  // 8 KiB of video memory, 0x8000..0x9FFF
  logic [7:0] mem [8192];
  logic       in_range;

  assign in_range = (addr[15:13] == `TILE_BASE_U >> 13);

  // read data follows the address in the same dot
  // anything outside video memory reads back as open bus
  assign rdata = in_range ? mem[addr[12:0]] : 8'hFF;

  // preload from the testbench
  task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
    mem[a[12:0]] = d;
  endtask

  // backdoor read for the reference model
  function automatic logic [7:0] read_byte(input logic [15:0] a);
    return mem[a[12:0]];
  endfunction

endmodule

`default_nettype wire

// ==== logic/ppu_bg_top.sv ====
`default_nettype none

module ppu_bg_top (
  input  logic                    clk,
  input  logic                    reset,
  input  ppu_reg_pkg::ppu_regs_t  regs,
  output logic                    vram_read_req,
  output logic [15:0]             vram_addr,
  input  logic [7:0]              vram_rdata,
  output logic                    lcd_valid,
  output ppu_pix_pkg::lcd_pixel_t lcd_px,
  output logic [7:0]              ly,
  output logic                    mode3
);

  ppu_reg_pkg::line_pos_t pos;
  logic                   line_start;
  logic                   line_done;

  // fetcher to fifo
  logic                   row_push;
  ppu_pix_pkg::tile_row_t row;

  // fifo to shifter
  logic                   pop;
  ppu_pix_pkg::bg_pixel_t head;
  logic                   fifo_empty;

  assign ly = pos.ly;

  dot_timer u_dot_timer (
    .clk        (clk),
    .reset      (reset),
    .pos        (pos),
    .line_start (line_start),
    .mode3      (mode3),
    .line_done  (line_done)
  );

  bg_fetcher u_bg_fetcher (
    .clk           (clk),
    .reset         (reset),
    .line_start    (line_start),
    .mode3         (mode3),
    .regs          (regs),
    .ly            (pos.ly),
    .vram_read_req (vram_read_req),
    .vram_addr     (vram_addr),
    .vram_rdata    (vram_rdata),
    .fifo_empty    (fifo_empty),
    .row_push      (row_push),
    .row           (row)
  );

  bg_fifo u_bg_fifo (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .row_push   (row_push),
    .pop        (pop),
    .row        (row),
    .head       (head),
    .fifo_empty (fifo_empty)
  );

  pixel_shifter u_pixel_shifter (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .mode3      (mode3),
    .regs       (regs),
    .head       (head),
    .fifo_empty (fifo_empty),
    .pop        (pop),
    .lcd_valid  (lcd_valid),
    .lcd_px     (lcd_px),
    .line_done  (line_done)
  );

endmodule

`default_nettype wire

// ==== logic/pixel_shifter.sv ====
`default_nettype none

`include "ppu_params.svh"

module pixel_shifter (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    line_start,
  input  logic                    mode3,
  input  ppu_reg_pkg::ppu_regs_t  regs,
  input  ppu_pix_pkg::bg_pixel_t  head,
  input  logic                    fifo_empty,
  output logic                    pop,
  output logic                    lcd_valid,
  output ppu_pix_pkg::lcd_pixel_t lcd_px,
  output logic                    line_done
);

  // fine scroll pixels still to throw away
  logic [2:0] discard;
  // screen column of the next pixel out
  logic [7:0] scr_x;
  logic       take;
  logic       line_full;

  // stop popping once 160 pixels went out, mode3 drops a dot later
  assign line_full = (scr_x == 8'(`SCREEN_W));
  assign pop       = mode3 && !fifo_empty && !line_full;
  assign take      = pop && head.valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      discard   <= '0;
      scr_x     <= '0;
      lcd_valid <= 1'b0;
      line_done <= 1'b0;
    end else if (line_start) begin
      // scx is sampled once per line
      discard   <= regs.scx[2:0];
      scr_x     <= '0;
      lcd_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      lcd_valid <= 1'b0;
      line_done <= 1'b0;
      if (take) begin
        if (discard != 3'd0) begin
          discard <= discard - 3'd1;
        end else begin
          lcd_valid <= 1'b1;
          scr_x     <= scr_x + 8'd1;
          // comes out together with the 160th pixel
          line_done <= (scr_x == 8'(`SCREEN_W - 1));
        end
      end
    end
  end

  // palette lookup, colour c selects bgp[2c+1:2c]
  always_ff @(posedge clk) begin
    if (take) begin
      lcd_px.shade <= regs.bgp[{head.color, 1'b0} +: 2];
      lcd_px.x     <= scr_x;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bg_fifo.sv ====
`default_nettype none

`include "ppu_params.svh"

module bg_fifo (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   line_start,
  input  logic                   row_push,
  input  logic                   pop,
  input  ppu_pix_pkg::tile_row_t row,
  output ppu_pix_pkg::bg_pixel_t head,
  output logic                   fifo_empty
);

  localparam int ptr_w  = $clog2(`FIFO_DEPTH);
  localparam int cnt_w  = ptr_w + 1;
  localparam int tile_w = 8;

  ppu_pix_pkg::bg_pixel_t mem [`FIFO_DEPTH];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign fifo_empty = (count == '0);
  assign do_pop     = pop && !fifo_empty;
  // a whole row must fit
  assign do_push    = row_push && (count <= cnt_w'(`FIFO_DEPTH - tile_w));

  // nothing valid at the head while empty
  assign head = fifo_empty ? '0 : mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (line_start) begin
      // leftovers of the previous line are dropped
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + ptr_w'(tile_w);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + ptr_w'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + cnt_w'(tile_w);
        2'b01:   count <= count - cnt_w'(1);
        2'b11:   count <= count + cnt_w'(tile_w - 1);
        default: count <= count;
      endcase
    end
  end

  // unpack both planes, leftmost pixel (bit 7) goes in first
  always_ff @(posedge clk) begin
    if (do_push) begin
      for (int i = 0; i < tile_w; i++) begin
        mem[wr_ptr + ptr_w'(i)] <= '{color: {row.high_byte[7-i], row.low_byte[7-i]},
                                     valid: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

// ==== fetcher/bg_fetcher.sv ====
`default_nettype none

`include "ppu_params.svh"

module bg_fetcher (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   line_start,
  input  logic                   mode3,
  input  ppu_reg_pkg::ppu_regs_t regs,
  input  logic [7:0]             ly,
  output logic                   vram_read_req,
  output logic [15:0]            vram_addr,
  input  logic [7:0]             vram_rdata,
  input  logic                   fifo_empty,
  output logic                   row_push,
  output ppu_pix_pkg::tile_row_t row
);

  ppu_pix_pkg::fetch_state_t state;

  // 0 puts the address out, 1 takes the read data
  logic       phase;
  // tiles fetched so far on this line
  logic [4:0] fetch_x;
  logic [7:0] tile_index;

  // background line after vertical scroll
  logic [7:0]  bg_y;
  // tile map column, wraps at 32
  logic [4:0]  tile_col;
  logic [15:0] map_addr;
  // address of the low plane of the current tile row
  logic [15:0] data_addr;
  logic [15:0] row_offset;

  assign bg_y     = regs.scy + ly;
  assign tile_col = regs.scx[7:3] + fetch_x;

  // 32x32 map, one byte per tile, row from bg_y[7:3]
  assign map_addr = (regs.lcdc[3] ? `MAP_BASE_HI : `MAP_BASE_LO)
                  + {6'd0, bg_y[7:3], tile_col};

  // two bytes per tile row, 16 bytes per tile
  assign row_offset = {12'd0, bg_y[2:0], 1'b0};

  always_comb begin
    if (regs.lcdc[4]) begin
      // unsigned index from 0x8000
      data_addr = `TILE_BASE_U + {4'd0, tile_index, 4'd0} + row_offset;
    end else begin
      // signed index around 0x9000, 128..255 land in 0x8800..0x8FFF
      data_addr = `TILE_BASE_S + {{4{tile_index[7]}}, tile_index, 4'd0} + row_offset;
    end
  end

  // fifo takes the whole row in one dot, only when it is empty
  assign row_push = mode3 && (state == ppu_pix_pkg::push) && fifo_empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= ppu_pix_pkg::get_tile;
      phase         <= 1'b0;
      fetch_x       <= '0;
      vram_read_req <= 1'b0;
      vram_addr     <= '0;
    end else if (line_start) begin
      // every line starts again at the scrolled left edge
      state         <= ppu_pix_pkg::get_tile;
      phase         <= 1'b0;
      fetch_x       <= '0;
      vram_read_req <= 1'b0;
    end else if (mode3) begin
      case (state)
        ppu_pix_pkg::get_tile: begin
          if (!phase) begin
            vram_addr     <= map_addr;
            vram_read_req <= 1'b1;
            phase         <= 1'b1;
          end else begin
            vram_read_req <= 1'b0;
            phase         <= 1'b0;
            state         <= ppu_pix_pkg::get_low;
          end
        end
        ppu_pix_pkg::get_low: begin
          if (!phase) begin
            vram_addr     <= data_addr;
            vram_read_req <= 1'b1;
            phase         <= 1'b1;
          end else begin
            vram_read_req <= 1'b0;
            phase         <= 1'b0;
            state         <= ppu_pix_pkg::get_high;
          end
        end
        ppu_pix_pkg::get_high: begin
          if (!phase) begin
            // high plane follows the low plane
            vram_addr     <= data_addr + 16'd1;
            vram_read_req <= 1'b1;
            phase         <= 1'b1;
          end else begin
            vram_read_req <= 1'b0;
            phase         <= 1'b0;
            state         <= ppu_pix_pkg::sleep;
          end
        end
        ppu_pix_pkg::sleep: begin
          // two idle dots
          phase <= ~phase;
          if (phase) begin
            state <= ppu_pix_pkg::push;
          end
        end
        ppu_pix_pkg::push: begin
          // stall here until the fifo drains
          if (fifo_empty) begin
            fetch_x <= fetch_x + 5'd1;
            state   <= ppu_pix_pkg::get_tile;
          end
        end
        default: begin
          state <= ppu_pix_pkg::get_tile;
          phase <= 1'b0;
        end
      endcase
    end else begin
      vram_read_req <= 1'b0;
    end
  end

  // read data is valid in the second dot of each read step
  always_ff @(posedge clk) begin
    if (mode3 && phase) begin
      case (state)
        ppu_pix_pkg::get_tile: tile_index    <= vram_rdata;
        ppu_pix_pkg::get_low:  row.low_byte  <= vram_rdata;
        ppu_pix_pkg::get_high: row.high_byte <= vram_rdata;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/dot_timer.sv ====
`default_nettype none

`include "ppu_params.svh"

module dot_timer (
  input  logic                  clk,
  input  logic                  reset,
  output ppu_reg_pkg::line_pos_t pos,
  output logic                  line_start,
  output logic                  mode3,
  input  logic                  line_done
);

  // lines 144..153 are vertical blank, no pixel transfer there
  localparam logic [7:0] visible_lines = 8'd144;

  logic last_dot;
  logic last_line;

  assign last_dot  = (pos.x_clock == 9'(`DOTS_PER_LINE - 1));
  assign last_line = (pos.ly == 8'(`LINES_PER_FRAME - 1));

  // dot and line counters, both wrap
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pos.x_clock <= '0;
      pos.ly      <= '0;
    end else if (last_dot) begin
      pos.x_clock <= '0;
      // next line, or back to the top of the frame
      pos.ly      <= last_line ? 8'd0 : pos.ly + 8'd1;
    end else begin
      pos.x_clock <= pos.x_clock + 9'd1;
    end
  end

  // one dot wide, only on visible lines
  assign line_start = (pos.x_clock == 9'(`MODE3_START_DOT)) && (pos.ly < visible_lines);

  // mode 3 opens the dot after line_start
  // and closes the dot after the last pixel leaves the shifter
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode3 <= 1'b0;
    end else if (line_done) begin
      mode3 <= 1'b0;
    end else if (line_start) begin
      mode3 <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== common/ppu_pix_pkg.sv ====
`default_nettype none

package ppu_pix_pkg;

  // one background pixel as held in the fifo
  typedef struct packed {
    logic [1:0] color;
    logic       valid;
  } bg_pixel_t;

  // both bit-planes of one tile row, bit 7 is the leftmost pixel
  typedef struct packed {
    logic [7:0] low_byte;
    logic [7:0] high_byte;
  } tile_row_t;

  // background fetcher steps, each read step takes two dots
  typedef enum logic [2:0] {
    get_tile,
    get_low,
    get_high,
    sleep,
    push
  } fetch_state_t;

  // shaded pixel toward the lcd with its screen column
  typedef struct packed {
    logic [1:0] shade;
    logic [7:0] x;
  } lcd_pixel_t;

endpackage

`default_nettype wire

// ==== common/ppu_reg_pkg.sv ====
`default_nettype none

package ppu_reg_pkg;

  // cpu-visible registers the background path reads
  // lcdc bit 3 picks the tile map, bit 4 picks the tile data addressing
  typedef struct packed {
    logic [7:0] lcdc;
    // vertical scroll
    logic [7:0] scy;
    // horizontal scroll, coarse in [7:3], fine in [2:0]
    logic [7:0] scx;
    // four 2-bit shades, colour 0 in [1:0]
    logic [7:0] bgp;
  } ppu_regs_t;

  // beam position inside the frame
  typedef struct packed {
    // dot within the line, 0..455
    logic [8:0] x_clock;
    // current scanline, 0..153
    logic [7:0] ly;
  } line_pos_t;

endpackage

`default_nettype wire

// ==== common/ppu_params.svh ====
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// visible pixels per scanline
`define SCREEN_W 160

// dots per scanline and scanlines per frame
`define DOTS_PER_LINE 456
`define LINES_PER_FRAME 154

// pixel transfer opens after the 80 dots of oam search
`define MODE3_START_DOT 80

// background fifo holds two tile rows
`define FIFO_DEPTH 16

// tile map and tile data bases in video memory
`define MAP_BASE_LO 16'h9800
`define MAP_BASE_HI 16'h9C00
`define TILE_BASE_U 16'h8000
`define TILE_BASE_S 16'h9000

`endif
